// File: Bender.yml
package:
  name: lcd_pattern

sources:
  # design, package first
  - files:
      - source/lcd_pattern_pkg.sv
      - source/write_pacer.sv
      - source/pattern_gen.sv
      - source/sdram_write_if.sv
      - source/lcd_pattern_top.sv

  # testbench, top module lcd_pattern_tb
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/lcd_pattern_tb.sv

// File: lcd_pattern.f
source/lcd_pattern_pkg.sv
source/write_pacer.sv
source/pattern_gen.sv
source/sdram_write_if.sv
source/lcd_pattern_top.sv
tb/tb_clk_gen.sv
tb/lcd_pattern_tb.sv

// File: source/lcd_pattern_pkg.sv
package lcd_pattern_pkg;

    // ------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------

    // rgb 8|8|8, red in the top byte
    typedef logic [23:0] pixel_t;

    // column or row position, wide enough for 2047 lines
    typedef logic [10:0] coord_t;

    // framebuffer word address for the controller window
    typedef logic [31:0] fb_addr_t;

    // write divide, period is value + 1 clocks
    typedef logic [7:0] divide_t;

    // ------------------------------------------------------------
    // generator control
    // ------------------------------------------------------------

    // fill walks the window, hold idles between frames
    typedef enum logic
    {
        gen_fill = 1'b0,
        gen_hold = 1'b1
    } gen_state_e;

    // ------------------------------------------------------------
    // pixel beat, execute stage to result stage
    // ------------------------------------------------------------

    // sof marks the first pixel of a frame only
    typedef struct packed
    {
        pixel_t data;
        logic   sof;
    } pix_beat_t;

endpackage

// File: source/lcd_pattern_top.sv
`timescale 1ns/1ps

module lcd_pattern_top
#(
    parameter int h_disp    = 640,
    parameter int v_disp    = 480,
    parameter int hold_log2 = 22
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sys_valid,
    input  lcd_pattern_pkg::divide_t    divide_param,
    output logic                        sys_we,
    output lcd_pattern_pkg::pixel_t     sys_data,
    output logic                        sys_load,
    output lcd_pattern_pkg::fb_addr_t   sys_addr_min,
    output lcd_pattern_pkg::fb_addr_t   sys_addr_max,
    output logic                        frame_done
);

    import lcd_pattern_pkg::*;

    // ------------------------------------------------------------
    // stage links
    // ------------------------------------------------------------

    logic       period_start;
    logic       write_slot;
    logic       beat_vld;
    pix_beat_t  beat;

    // decode: divide setting to slot timing
    write_pacer u_pacer
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .divide_param (divide_param),
        .period_start (period_start),
        .write_slot   (write_slot)
    );

    // execute: raster walk and hold
    pattern_gen #(
        .h_disp    (h_disp),
        .v_disp    (v_disp),
        .hold_log2 (hold_log2)
    ) u_gen
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .sys_valid    (sys_valid),
        .period_start (period_start),
        .beat_vld     (beat_vld),
        .beat         (beat)
    );

    // result: strobes toward the sdram controller
    sdram_write_if #(
        .h_disp (h_disp),
        .v_disp (v_disp)
    ) u_wr
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_vld     (beat_vld),
        .beat         (beat),
        .write_slot   (write_slot),
        .sys_we       (sys_we),
        .sys_data     (sys_data),
        .sys_load     (sys_load),
        .sys_addr_min (sys_addr_min),
        .sys_addr_max (sys_addr_max),
        .frame_done   (frame_done)
    );

endmodule

// File: source/pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen
#(
    parameter int h_disp    = 640,
    parameter int v_disp    = 480,
    parameter int hold_log2 = 22
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sys_valid,
    input  logic                        period_start,
    output logic                        beat_vld,
    output lcd_pattern_pkg::pix_beat_t  beat
);

    import lcd_pattern_pkg::*;

    // ------------------------------------------------------------
    // window bounds
    // ------------------------------------------------------------

    // middle half of the frame, all columns
    localparam coord_t col_last  = coord_t'(h_disp - 1);
    localparam coord_t row_first = coord_t'(v_disp / 4);
    localparam coord_t row_last  = coord_t'(3 * v_disp / 4 - 1);

    gen_state_e             state;
    coord_t                 col;
    coord_t                 row;
    logic [hold_log2-1:0]   hold_cnt;
    logic                   sof_next;
    logic                   tick;

    // one step per write period, frozen while the controller is not ready
    assign tick = period_start & sys_valid;

    // ------------------------------------------------------------
    // raster walker and fill/hold fsm
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= gen_fill;
            col      <= '0;
            row      <= row_first;
            hold_cnt <= '0;
            sof_next <= 1'b1;
            beat_vld <= 1'b0;
        end
        else
        begin
            // single cycle strobe
            beat_vld <= 1'b0;
            if (tick)
            begin
                case (state)
                    gen_fill:
                    begin
                        beat_vld <= 1'b1;
                        sof_next <= 1'b0;
                        if (col != col_last)
                            col <= col + 11'd1;
                        else
                        begin
                            col <= '0;
                            if (row != row_last)
                                row <= row + 11'd1;
                            else
                            begin
                                // last pixel of the window just went out
                                state    <= gen_hold;
                                hold_cnt <= '0;
                            end
                        end
                    end
                    gen_hold:
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                        // 2**hold_log2 ticks, then rewind to the window start
                        if (hold_cnt == '1)
                        begin
                            state    <= gen_fill;
                            col      <= '0;
                            row      <= row_first;
                            sof_next <= 1'b1;
                        end
                    end
                    default:
                    begin
                        state <= gen_hold;
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // pixel payload
    // ------------------------------------------------------------

    // value is column + row, zero extended
    always_ff @(posedge clk)
    begin
        if (tick && state == gen_fill)
        begin
            beat.data <= pixel_t'({1'b0, col} + {1'b0, row});
            beat.sof  <= sof_next;
        end
    end

    // walker must wrap before leaving the line
    a_col_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        col < coord_t'(h_disp));

endmodule

// File: source/sdram_write_if.sv
`timescale 1ns/1ps

module sdram_write_if
#(
    parameter int h_disp = 640,
    parameter int v_disp = 480
)
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        beat_vld,
    input  lcd_pattern_pkg::pix_beat_t  beat,
    input  logic                        write_slot,
    output logic                        sys_we,
    output lcd_pattern_pkg::pixel_t     sys_data,
    output logic                        sys_load,
    output lcd_pattern_pkg::fb_addr_t   sys_addr_min,
    output lcd_pattern_pkg::fb_addr_t   sys_addr_max,
    output logic                        frame_done
);

    import lcd_pattern_pkg::*;

    // ------------------------------------------------------------
    // window geometry
    // ------------------------------------------------------------

    localparam int       frame_beats = h_disp * v_disp / 2;
    localparam int       cnt_w       = $clog2(frame_beats + 1);
    localparam fb_addr_t addr_lo     = fb_addr_t'(h_disp * v_disp / 4);
    localparam fb_addr_t addr_hi     = fb_addr_t'(3 * h_disp * v_disp / 4);

    logic               pend;
    logic               pend_sof;
    pixel_t             pend_data;
    logic [cnt_w-1:0]   beat_cnt;
    logic               issue;

    // pending beat meets its slot
    assign issue = pend & write_slot;

    // ------------------------------------------------------------
    // pending beat and write strobes
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend         <= 1'b0;
            sys_we       <= 1'b0;
            sys_data     <= '0;
            sys_load     <= 1'b0;
            beat_cnt     <= '0;
            frame_done   <= 1'b0;
            sys_addr_min <= addr_lo;
            sys_addr_max <= addr_hi;
        end
        else
        begin
            // a new beat may land in the same cycle the old one goes out
            pend     <= beat_vld | (pend & ~write_slot);
            sys_load <= beat_vld & beat.sof;
            sys_we   <= issue;
            if (issue)
            begin
                sys_data <= pend_data;
                // count restarts with the frame's first write
                beat_cnt <= pend_sof ? cnt_w'(1) : beat_cnt + 1'b1;
            end
            // last write of the frame was on the bus this cycle
            frame_done <= sys_we && (beat_cnt == cnt_w'(frame_beats));
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat_vld)
        begin
            pend_data <= beat.data;
            pend_sof  <= beat.sof;
        end
    end

    // pacer guarantees a slot between two period starts
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        beat_vld |-> (!pend || write_slot));

    a_cnt_in_window: assert property (@(posedge clk) disable iff (!rst_n)
        beat_cnt <= cnt_w'(frame_beats));

endmodule

// File: source/write_pacer.sv
`timescale 1ns/1ps

module write_pacer
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  lcd_pattern_pkg::divide_t  divide_param,
    output logic                      period_start,
    output logic                      write_slot
);

    import lcd_pattern_pkg::*;

    // ------------------------------------------------------------
    // period counter
    // ------------------------------------------------------------

    divide_t    cnt;
    divide_t    divide_q;
    logic [8:0] mid_slot;

    // runs 0..divide_param then wraps
    // a new divide value restarts at zero
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt      <= '0;
            divide_q <= '0;
        end
        else
        begin
            divide_q <= divide_param;
            if (divide_param != divide_q || cnt >= divide_param)
                cnt <= '0;
            else
                cnt <= cnt + 8'd1;
        end
    end

    // ------------------------------------------------------------
    // slot decode
    // ------------------------------------------------------------

    // middle of the period
    // 9 bits so 255 + 1 does not wrap
    assign mid_slot = ({1'b0, divide_param} + 9'd1) >> 1;

    assign period_start = (cnt == '0);

    // every cycle is a slot at divide 0
    // divide 1 lands on the second cycle of the pair
    assign write_slot = (divide_param == 8'd0) ? 1'b1 :
                                                 (cnt == mid_slot[7:0]);

endmodule

// File: tb/lcd_pattern_tb.sv
`timescale 1ns/1ps

module lcd_pattern_tb;

    import lcd_pattern_pkg::*;

    // small 16 x 8 frame with a 64 beat window
    localparam int h_disp      = 16;
    localparam int v_disp      = 8;
    localparam int hold_log2   = 4;
    // window rows, first one and the one past the last
    localparam int row_first   = v_disp / 4;
    localparam int row_end     = 3 * v_disp / 4;
    localparam int frame_beats = (row_end - row_first) * h_disp;
    localparam int hold_ticks  = 1 << hold_log2;
    // word addresses of the first window row and of the row after the window
    localparam int addr_min    = row_first * h_disp;
    localparam int addr_max    = row_end * h_disp;
    // four frames at divide 3 take about (64 + 16) * 4 * 4 = 1280 cycles
    localparam int max_cycles  = 20000;

    logic       clk;
    logic       rst_n;
    logic       sys_valid;
    divide_t    divide_param;
    logic       sys_we;
    pixel_t     sys_data;
    logic       sys_load;
    fb_addr_t   sys_addr_min;
    fb_addr_t   sys_addr_max;
    logic       frame_done;

    // event log filled by the monitor
    int         cyc = 0;
    pixel_t     we_data[$];
    int         we_cyc[$];
    int         load_cyc[$];
    int         done_cyc[$];

    int             errors = 0;
    int             checks = 0;
    int             failed_tests = 0;
    logic [31:0]    lcg_state;

    tb_clk_gen #(.period_ns(20), .reset_cycles(5)) u_clk
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lcd_pattern_top #(
        .h_disp    (h_disp),
        .v_disp    (v_disp),
        .hold_log2 (hold_log2)
    ) u_dut
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .sys_valid    (sys_valid),
        .divide_param (divide_param),
        .sys_we       (sys_we),
        .sys_data     (sys_data),
        .sys_load     (sys_load),
        .sys_addr_min (sys_addr_min),
        .sys_addr_max (sys_addr_max),
        .frame_done   (frame_done)
    );

    // ------------------------------------------------------------
    // monitor and watchdog
    // ------------------------------------------------------------

    // outputs are registered so the edge sees last cycle's values
    always @(posedge clk)
    begin
        cyc = cyc + 1;
        if (sys_we)
        begin
            we_data.push_back(sys_data);
            we_cyc.push_back(cyc);
        end
        if (sys_load)
            load_cyc.push_back(cyc);
        if (frame_done)
            done_cyc.push_back(cyc);
    end

    initial
    begin
        wait (cyc >= max_cycles);
        $display("timeout: tests still running after %0d clock cycles", max_cycles);
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // raster order over the window with value column + row
    function automatic pixel_t expected_pixel(int idx);
        int col;
        int row;
        col = idx % h_disp;
        row = row_first + idx / h_disp;
        return pixel_t'(col + row);
    endfunction

    task automatic expect_equal(input string what, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic confirm_idle(input string when);
        expect_equal({when, ": sys_we"}, sys_we, 0);
        expect_equal({when, ": sys_load"}, sys_load, 0);
        expect_equal({when, ": frame_done"}, frame_done, 0);
        expect_equal({when, ": sys_data"}, sys_data, 0);
        expect_equal({when, ": sys_addr_min"}, sys_addr_min, addr_min);
        expect_equal({when, ": sys_addr_max"}, sys_addr_max, addr_max);
    endtask

    // sampled on the falling edge after the monitor has logged
    task automatic wait_frame_done(input int done_base);
        while (done_cyc.size() <= done_base)
            @(negedge clk);
    endtask

    // one load ahead of the writes
    // then 64 writes in model order and one done
    task automatic audit_frame(input string tag, input int we_base, input int load_base,
                               input int done_base, input int spacing);
        int n_we;
        n_we = we_data.size() - we_base;
        expect_equal({tag, ": write count"}, n_we, frame_beats);
        expect_equal({tag, ": load pulses"}, load_cyc.size() - load_base, 1);
        expect_equal({tag, ": done pulses"}, done_cyc.size() - done_base, 1);
        if (n_we > 0 && load_cyc.size() > load_base)
            expect_equal({tag, ": load before first write"},
                         load_cyc[load_base] < we_cyc[we_base], 1);
        if (n_we > 0 && done_cyc.size() > done_base)
            expect_equal({tag, ": done after last write"},
                         done_cyc[done_base] - we_cyc[we_cyc.size() - 1], 1);
        for (int i = 0; i < n_we; i++)
        begin
            expect_equal($sformatf("%s: pixel %0d", tag, i),
                         we_data[we_base + i], expected_pixel(i));
            // zero means sys_valid was not steady and spacing is free
            if (spacing > 0 && i > 0)
                expect_equal($sformatf("%s: spacing before pixel %0d", tag, i),
                             we_cyc[we_base + i] - we_cyc[we_base + i - 1], spacing);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
            $display("%s: ok", name);
        else
        begin
            $display("%s: %0d errors", name, errors - err_before);
            failed_tests++;
        end
    endtask

    // ------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------

    // with sys_valid low nothing may move after release either
    task automatic reset_state_test();
        int err0;
        err0 = errors;
        while (rst_n !== 1'b1)
        begin
            @(negedge clk);
            confirm_idle("in reset");
        end
        repeat (4)
        begin
            @(negedge clk);
            confirm_idle("after reset");
        end
        report_test("reset state", err0);
    endtask

    task automatic full_frame_test();
        int err0;
        int we_base;
        int load_base;
        int done_base;
        err0      = errors;
        we_base   = we_data.size();
        load_base = load_cyc.size();
        done_base = done_cyc.size();
        @(posedge clk);
        sys_valid <= 1'b1;
        wait_frame_done(done_base);
        audit_frame("divide 0", we_base, load_base, done_base, 1);
        report_test("full frame at divide 0", err0);
    endtask

    // divide changes while the generator holds
    task automatic pacing_test();
        int err0;
        int we_base;
        int load_base;
        int done_base;
        err0      = errors;
        we_base   = we_data.size();
        load_base = load_cyc.size();
        done_base = done_cyc.size();
        @(posedge clk);
        divide_param <= 8'd3;
        wait_frame_done(done_base);
        audit_frame("divide 3", we_base, load_base, done_base, 4);
        report_test("pacing at divide 3", err0);
    endtask

    task automatic random_valid_test();
        int          err0;
        int          we_base;
        int          load_base;
        int          done_base;
        logic [31:0] rnd;
        err0      = errors;
        we_base   = we_data.size();
        load_base = load_cyc.size();
        done_base = done_cyc.size();
        @(posedge clk);
        divide_param <= 8'd1;
        // a fresh coin per cycle until the frame closes
        while (done_cyc.size() <= done_base)
        begin
            @(posedge clk);
            rnd = lcg_next();
            sys_valid <= rnd[16];
            @(negedge clk);
        end
        @(posedge clk);
        sys_valid <= 1'b1;
        audit_frame("random valid", we_base, load_base, done_base, 0);
        report_test("random sys_valid at divide 1", err0);
    endtask

    task automatic repeat_test();
        int err0;
        int we_base;
        int load_base;
        int done_base;
        err0      = errors;
        we_base   = we_data.size();
        load_base = load_cyc.size();
        done_base = done_cyc.size();
        wait_frame_done(done_base);
        audit_frame("repeat", we_base, load_base, done_base, 2);
        // hold ticks separate the previous done from the new load
        if (load_cyc.size() > load_base)
            expect_equal("repeat: hold before new load",
                         load_cyc[load_base] - done_cyc[done_base - 1] > hold_ticks, 1);
        if (we_data.size() > we_base)
            expect_equal("repeat: first pixel", we_data[we_base], row_first);
        report_test("frame repetition", err0);
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------

    initial
    begin
        sys_valid    = 1'b0;
        divide_param = '0;
        lcg_state    = 32'h6cdf;
        reset_state_test();
        full_frame_test();
        pacing_test();
        random_valid_test();
        repeat_test();
        $display("tests: 5, failed tests: %0d, checks: %0d, errors: %0d",
                 failed_tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
#(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 5
)
(
    output logic clk,
    output logic rst_n
);

    // free running clock, half period per phase
    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset held low for the first few rising edges
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
